// ==== design/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;     // operands, results, bus data
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] apb_addr_t;

    localparam int        NUM_REGS           = 32;
    localparam reg_addr_t LINK_FREE_ZERO_REG = 5'd0;  // hardwired zero

    // primary opcode field, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // function field of SPECIAL, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam apb_addr_t ADDR_INST     = 12'h000;
    localparam apb_addr_t ADDR_STATUS   = 12'h004;
    localparam apb_addr_t ADDR_REG_BASE = 12'h080;  // reg n at base + 4n

    typedef enum logic [3:0] {
        ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_NOP} alu_sel_e;

    typedef struct packed {
        logic  valid;
        word_t inst;
    } issue_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        alu_sel_e  sel;
        word_t     operand_a;
        word_t     operand_b;
        reg_addr_t wd;
        logic      wreg;
    } id_ex_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } ex_wb_t;

    // result group of an operation
    function automatic alu_sel_e op_group(alu_op_e op);
        case (op)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA: return SEL_SHIFT;
            ALU_NOP: return SEL_NOP;
            default: return SEL_ARITH;
        endcase
    endfunction

endpackage

// ==== design/apb_host_port.sv ====
`timescale 1ns/1ps

module apb_host_port (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  mips_pkg::apb_addr_t paddr_i,
    input  mips_pkg::word_t     pwdata_i,
    input  logic                busy_i,
    input  logic                illegal_i,
    input  mips_pkg::word_t     rdata_i,
    output mips_pkg::word_t     prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    output mips_pkg::issue_t    issue_o,
    output mips_pkg::reg_addr_t raddr_o
);
    import mips_pkg::*;

    logic access;
    logic hit_inst;
    logic hit_status;
    logic hit_reg;
    logic bad;
    logic illegal_q;  // sticky

    assign access     = psel_i & penable_i;
    assign hit_inst   = (paddr_i == ADDR_INST);
    assign hit_status = (paddr_i == ADDR_STATUS);
    // 0x080..0x0fc, word aligned
    assign hit_reg    = (paddr_i[11:7] == ADDR_REG_BASE[11:7]) && (paddr_i[1:0] == 2'b00);

    // inst address is write only, everything else read only
    assign bad = pwrite_i ? !hit_inst : !(hit_status | hit_reg);

    // reads wait for the pipeline to drain
    assign pready_o  = access & (bad | pwrite_i | !busy_i);
    assign pslverr_o = access & bad;

    assign issue_o.valid = access & pwrite_i & hit_inst;
    assign issue_o.inst  = pwdata_i;

    assign raddr_o = paddr_i[6:2];

    always_comb begin
        prdata_o = '0;
        if (hit_status) begin
            prdata_o = {30'b0, busy_i, illegal_q};
        end else if (hit_reg) begin
            prdata_o = rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            illegal_q <= 1'b0;
        end else if (illegal_i) begin
            illegal_q <= 1'b1;
        end
    end

    // ready only in an access phase, after a setup or wait cycle
    a_ready_in_access: assert property (@(posedge clk) disable iff (rst_i)
        pready_o |-> $past(psel_i) && !$past(pready_o));

endmodule

// ==== design/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  logic                clk,
    input  logic                rst_i,
    input  mips_pkg::issue_t    issue_i,
    input  mips_pkg::word_t     rdata_a_i,
    input  mips_pkg::word_t     rdata_b_i,
    input  mips_pkg::ex_wb_t    ex_fwd_i,
    input  mips_pkg::ex_wb_t    wb_fwd_i,
    output mips_pkg::reg_addr_t raddr_a_o,
    output mips_pkg::reg_addr_t raddr_b_o,
    output mips_pkg::id_ex_t    id_ex_o,
    output logic                illegal_o,
    output logic                busy_o
);
    import mips_pkg::*;

    issue_t    dec_q;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t sa;
    alu_op_e   dec_op;
    word_t     imm;
    logic      imm_a;  // immediate shifts, shamt as operand a
    logic      imm_b;
    logic      shamt_form;
    reg_addr_t wd;

    // execute result first, then writeback, then the array
    function automatic word_t bypass(reg_addr_t addr, word_t rf_data, ex_wb_t ex, ex_wb_t wb);
        if (addr == LINK_FREE_ZERO_REG) begin
            return '0;
        end
        if (ex.wreg && ex.wd == addr) begin
            return ex.wdata;
        end
        if (wb.wreg && wb.wd == addr) begin
            return wb.wdata;
        end
        return rf_data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q <= issue_i;
        end
    end

    assign opcode = dec_q.inst[31:26];
    assign rs     = dec_q.inst[25:21];
    assign rt     = dec_q.inst[20:16];
    assign rd     = dec_q.inst[15:11];
    assign sa     = dec_q.inst[10:6];
    assign funct  = dec_q.inst[5:0];
    assign shamt_form = (opcode == OP_SPECIAL) && (funct inside {FN_SLL, FN_SRL, FN_SRA});

    always_comb begin
        dec_op = ALU_NOP;
        imm    = '0;
        imm_a  = 1'b0;
        imm_b  = 1'b0;
        wd     = rd;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_OR:           dec_op = ALU_OR;
                    FN_AND:          dec_op = ALU_AND;
                    FN_XOR:          dec_op = ALU_XOR;
                    FN_NOR:          dec_op = ALU_NOR;
                    FN_SLL, FN_SLLV: dec_op = ALU_SLL;
                    FN_SRL, FN_SRLV: dec_op = ALU_SRL;
                    FN_SRA, FN_SRAV: dec_op = ALU_SRA;
                    FN_ADD, FN_ADDU: dec_op = ALU_ADD;
                    FN_SUB, FN_SUBU: dec_op = ALU_SUB;
                    FN_SLT:          dec_op = ALU_SLT;
                    FN_SLTU:         dec_op = ALU_SLTU;
                    default:         dec_op = ALU_NOP;
                endcase
                if (shamt_form) begin
                    imm   = {27'b0, sa};
                    imm_a = 1'b1;
                end
                if (shamt_form ? (rs != '0) : (sa != '0)) begin
                    dec_op = ALU_NOP;  // reserved fields must be zero
                end
            end
            OP_ORI, OP_LUI:    dec_op = ALU_OR;  // lui is rs | imm<<16
            OP_ANDI:           dec_op = ALU_AND;
            OP_XORI:           dec_op = ALU_XOR;
            OP_ADDI, OP_ADDIU: dec_op = ALU_ADD;
            OP_SLTI:           dec_op = ALU_SLT;
            OP_SLTIU:          dec_op = ALU_SLTU;
            default:           dec_op = ALU_NOP;
        endcase
        if (opcode != OP_SPECIAL) begin
            imm_b = 1'b1;
            wd    = rt;
            if (opcode == OP_LUI) begin
                imm = {dec_q.inst[15:0], 16'h0};
            end else if (op_group(dec_op) == SEL_LOGIC) begin
                imm = {16'h0, dec_q.inst[15:0]};
            end else begin
                imm = {{16{dec_q.inst[15]}}, dec_q.inst[15:0]};
            end
        end
    end

    assign raddr_a_o = rs;
    assign raddr_b_o = rt;

    assign id_ex_o.valid     = dec_q.valid;
    assign id_ex_o.op        = dec_op;
    assign id_ex_o.sel       = op_group(dec_op);
    assign id_ex_o.operand_a = imm_a ? imm : bypass(rs, rdata_a_i, ex_fwd_i, wb_fwd_i);
    assign id_ex_o.operand_b = imm_b ? imm : bypass(rt, rdata_b_i, ex_fwd_i, wb_fwd_i);
    assign id_ex_o.wd        = wd;
    assign id_ex_o.wreg      = (dec_op != ALU_NOP);

    assign illegal_o = dec_q.valid & (dec_op == ALU_NOP);
    assign busy_o    = dec_q.valid;

    // an unknown word leaves execute without a write, and issues never come back to back
    a_illegal_no_write: assert property (@(posedge clk) disable iff (rst_i)
        illegal_o |=> !ex_fwd_i.wreg && !illegal_o);

endmodule

// ==== design/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic             clk,
    input  logic             rst_i,
    input  mips_pkg::id_ex_t id_ex_i,
    output mips_pkg::ex_wb_t result_o,
    output logic             busy_o
);
    import mips_pkg::*;

    id_ex_t     ex_q;
    logic [4:0] sh_amt;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_q.valid <= 1'b0;
        end else begin
            ex_q <= id_ex_i;
        end
    end

    assign sh_amt = ex_q.operand_a[4:0];  // shamt or rs[4:0]

    always_comb begin
        case (ex_q.op)
            ALU_OR:  logic_res = ex_q.operand_a | ex_q.operand_b;
            ALU_AND: logic_res = ex_q.operand_a & ex_q.operand_b;
            ALU_XOR: logic_res = ex_q.operand_a ^ ex_q.operand_b;
            ALU_NOR: logic_res = ~(ex_q.operand_a | ex_q.operand_b);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (ex_q.op)
            ALU_SLL: shift_res = ex_q.operand_b << sh_amt;
            ALU_SRL: shift_res = ex_q.operand_b >> sh_amt;
            ALU_SRA: shift_res = $signed(ex_q.operand_b) >>> sh_amt;
            default: shift_res = '0;
        endcase
    end

    // no overflow trap, add behaves as addu
    always_comb begin
        case (ex_q.op)
            ALU_ADD:  arith_res = ex_q.operand_a + ex_q.operand_b;
            ALU_SUB:  arith_res = ex_q.operand_a - ex_q.operand_b;
            ALU_SLT:  arith_res = {31'b0, $signed(ex_q.operand_a) < $signed(ex_q.operand_b)};
            ALU_SLTU: arith_res = {31'b0, ex_q.operand_a < ex_q.operand_b};
            default:  arith_res = '0;
        endcase
    end

    assign result_o.wreg = ex_q.valid & ex_q.wreg;
    assign result_o.wd   = ex_q.wd;

    always_comb begin
        case (ex_q.sel)
            SEL_LOGIC: result_o.wdata = logic_res;
            SEL_SHIFT: result_o.wdata = shift_res;
            SEL_ARITH: result_o.wdata = arith_res;
            default:   result_o.wdata = '0;
        endcase
    end

    assign busy_o = ex_q.valid;

    // a valid item that writes carries a real result group
    a_no_nop_write: assert property (@(posedge clk) disable iff (rst_i)
        ex_q.valid && ex_q.wreg |-> ex_q.sel != SEL_NOP);

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst_i,
    input  mips_pkg::ex_wb_t    wb_i,
    input  mips_pkg::reg_addr_t raddr_a_i,
    input  mips_pkg::reg_addr_t raddr_b_i,
    input  mips_pkg::reg_addr_t raddr_host_i,
    output mips_pkg::word_t     rdata_a_o,
    output mips_pkg::word_t     rdata_b_o,
    output mips_pkg::word_t     rdata_host_o,
    output mips_pkg::ex_wb_t    wb_fwd_o,
    output logic                busy_o
);
    import mips_pkg::*;

    ex_wb_t wb_q;  // writeback stage
    word_t  regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_q.wreg <= 1'b0;
        end else begin
            wb_q <= wb_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_q.wreg && wb_q.wd != LINK_FREE_ZERO_REG) begin
            regs[wb_q.wd] <= wb_q.wdata;
        end
    end

    // r0 is never written so it reads zero
    assign rdata_a_o    = regs[raddr_a_i];
    assign rdata_b_o    = regs[raddr_b_i];
    assign rdata_host_o = regs[raddr_host_i];

    assign wb_fwd_o = wb_q;
    assign busy_o   = wb_q.wreg;  // array write still pending

endmodule

// ==== design/mini_mips_core.sv ====
`timescale 1ns/1ps

module mini_mips_core (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  mips_pkg::apb_addr_t paddr_i,
    input  mips_pkg::word_t     pwdata_i,
    output mips_pkg::word_t     prdata_o,
    output logic                pready_o,
    output logic                pslverr_o
);
    import mips_pkg::*;

    issue_t    issue;
    id_ex_t    id_ex;
    ex_wb_t    ex_res;
    ex_wb_t    wb_fwd;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    reg_addr_t raddr_host;
    word_t     rdata_a;
    word_t     rdata_b;
    word_t     rdata_host;
    logic      illegal;
    logic      dec_busy;
    logic      ex_busy;
    logic      wb_busy;
    logic      busy;

    assign busy = dec_busy | ex_busy | wb_busy;  // any stage holds an item

    apb_host_port u_port (
        .clk(clk), .rst_i(rst_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .busy_i(busy), .illegal_i(illegal), .rdata_i(rdata_host),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .issue_o(issue), .raddr_o(raddr_host)
    );

    inst_decode u_decode (
        .clk(clk), .rst_i(rst_i), .issue_i(issue),
        .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
        .ex_fwd_i(ex_res), .wb_fwd_i(wb_fwd),
        .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .id_ex_o(id_ex),
        .illegal_o(illegal), .busy_o(dec_busy)
    );

    alu_execute u_execute (
        .clk(clk), .rst_i(rst_i), .id_ex_i(id_ex),
        .result_o(ex_res), .busy_o(ex_busy)
    );

    reg_file u_regs (
        .clk(clk), .rst_i(rst_i), .wb_i(ex_res),
        .raddr_a_i(raddr_a), .raddr_b_i(raddr_b), .raddr_host_i(raddr_host),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b), .rdata_host_o(rdata_host),
        .wb_fwd_o(wb_fwd), .busy_o(wb_busy)
    );

endmodule

// ==== sim/tb_mini_mips_model.svh ====
`ifndef TB_MINI_MIPS_MODEL_SVH
`define TB_MINI_MIPS_MODEL_SVH

word_t lfsr = 32'hc0aac5e9;
word_t shadow [32];  // expected register contents

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic word_t rand_bits(input int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs,
                                input int rt, input int sa);
    return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs,
                                input word_t imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

// register forms, a from rs and b from rt
function automatic word_t model_r(input logic [5:0] fn, input word_t a, input word_t b,
                                  input int sa);
    case (fn)
        FN_OR:           return a | b;
        FN_AND:          return a & b;
        FN_XOR:          return a ^ b;
        FN_NOR:          return ~(a | b);
        FN_SLL:          return b << sa[4:0];
        FN_SRL:          return b >> sa[4:0];
        FN_SRA:          return $signed(b) >>> sa[4:0];
        FN_SLLV:         return b << a[4:0];
        FN_SRLV:         return b >> a[4:0];
        FN_SRAV:         return $signed(b) >>> a[4:0];
        FN_ADD, FN_ADDU: return a + b;
        FN_SUB, FN_SUBU: return a - b;
        FN_SLT:          return {31'b0, $signed(a) < $signed(b)};
        FN_SLTU:         return {31'b0, a < b};
        default:         return a;
    endcase
endfunction

function automatic word_t model_i(input logic [5:0] op, input word_t a, input word_t imm);
    word_t zx;
    word_t sx;
    zx = {16'h0, imm[15:0]};
    sx = {{16{imm[15]}}, imm[15:0]};
    case (op)
        OP_ORI:            return a | zx;
        OP_ANDI:           return a & zx;
        OP_XORI:           return a ^ zx;
        OP_LUI:            return {imm[15:0], 16'h0};
        OP_ADDI, OP_ADDIU: return a + sx;
        OP_SLTI:           return {31'b0, $signed(a) < $signed(sx)};
        OP_SLTIU:          return {31'b0, a < sx};
        default:           return a;
    endcase
endfunction

task automatic set_reg(input int rd, input word_t val);
    if (rd != 0) begin
        shadow[rd] = val;  // r0 stays zero
    end
endtask

`endif

// ==== sim/tb_mini_mips.sv ====
`timescale 1ns/1ps

module tb_mini_mips;
    import mips_pkg::*;

    `include "tb_mini_mips_model.svh"

    localparam int MAX_CYCLES = 3000;

    logic      clk;
    logic      rst_i;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;
    logic      done_q;
    word_t     exp_data;
    logic      exp_err;
    int        cycles = 0;
    int        data_errors = 0;
    int        resp_errors = 0;
    logic [5:0] chain_fn [8] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU};

    mini_mips_core UUT (
        .clk(clk), .rst_i(rst_i),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        done_q <= psel & penable & pready;  // transfer completed on this edge
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    a_read_data: assert property (@(posedge clk) disable iff (rst_i)
        psel && penable && pready && !pwrite && !exp_err |-> prdata == exp_data)
    else begin
        data_errors++;
        $display("mismatch at %0t ns: read 0x%03h gave 0x%08h, expected 0x%08h",
                 $time, $sampled(paddr), $sampled(prdata), $sampled(exp_data));
    end

    a_resp_err: assert property (@(posedge clk) disable iff (rst_i)
        psel && penable && pready |-> pslverr == exp_err)
    else begin
        resp_errors++;
        $display("mismatch at %0t ns: pslverr %0b at 0x%03h, expected %0b",
                 $time, $sampled(pslverr), $sampled(paddr), $sampled(exp_err));
    end

    // starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                            input logic err);
        exp_err = err;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        do @(negedge clk); while (!done_q);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_inst(input word_t inst);
        apb_xfer(1'b1, ADDR_INST, inst, 1'b0);
    endtask

    task automatic read_reg(input int n);
        exp_data = shadow[n];
        apb_xfer(1'b0, ADDR_REG_BASE + apb_addr_t'(4 * n), '0, 1'b0);
    endtask

    task automatic read_status(input logic illegal);
        exp_data = {31'b0, illegal};  // busy always reads 0 once drained
        apb_xfer(1'b0, ADDR_STATUS, '0, 1'b0);
    endtask

    task automatic do_r(input logic [5:0] fn, input int rd, input int rs, input int rt,
                        input int sa);
        word_t res;
        res = model_r(fn, shadow[rs], shadow[rt], sa);
        write_inst(enc_r(fn, rd, rs, rt, sa));
        set_reg(rd, res);
    endtask

    task automatic do_i(input logic [5:0] op, input int rt, input int rs, input word_t imm);
        word_t res;
        res = model_i(op, shadow[rs], imm);
        write_inst(enc_i(op, rt, rs, imm));
        set_reg(rt, res);
    endtask

    initial begin
        int i;
        for (i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        rst_i    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        exp_data = '0;
        exp_err  = 1'b0;
        repeat (3) @(negedge clk);
        rst_i = 1'b0;
        read_status(1'b0);

        for (i = 1; i <= 4; i++) begin
            do_i(OP_LUI, i, 0, rand_bits(16));
            do_i(OP_ORI, i, i, rand_bits(16));
            do_i(OP_XORI, i + 4, i, rand_bits(16));
            do_i(OP_ANDI, i + 8, i, rand_bits(16));
        end
        for (i = 1; i <= 12; i++) read_reg(i);

        // each result feeds the next, issued with no gap
        for (i = 0; i < 16; i++) begin
            do_r(chain_fn[i % 8], 13 + i % 3, 13 + (i + 2) % 3, 1 + i % 12, 0);
        end
        for (i = 13; i <= 15; i++) read_reg(i);

        do_i(OP_LUI, 16, 0, 32'h8000 | rand_bits(15));  // negative source
        do_i(OP_ORI, 16, 16, rand_bits(16));
        do_r(FN_SLL, 17, 0, 16, rand_bits(5));
        do_r(FN_SRL, 18, 0, 16, rand_bits(5));
        do_r(FN_SRA, 19, 0, 16, rand_bits(5));
        do_r(FN_SLLV, 20, 1, 16, 0);
        do_r(FN_SRLV, 21, 2, 16, 0);
        do_r(FN_SRAV, 22, 3, 16, 0);
        for (i = 16; i <= 22; i++) read_reg(i);

        for (i = 0; i < 4; i++) begin
            do_r(FN_SLT, 23, 1 + i, 16, 0);
            do_r(FN_SLTU, 24, 16, 5 + i, 0);
            do_i(OP_SLTI, 25, 1 + i, rand_bits(16));
            do_i(OP_SLTIU, 26, 16, rand_bits(16));
            for (int r = 23; r <= 26; r++) read_reg(r);
        end

        write_inst({6'h3f, 26'b0} | rand_bits(26));
        write_inst(enc_r(6'b001000, 27, 1, 2, 0));  // jr is not decoded
        read_status(1'b1);
        for (i = 0; i < 32; i++) read_reg(i);
        do_r(FN_ADDU, 27, 1, 2, 0);
        read_reg(27);
        read_status(1'b1);

        do_i(OP_ORI, 0, 0, rand_bits(16));
        do_r(FN_ADDU, 0, 1, 2, 0);
        read_reg(0);
        apb_xfer(1'b1, ADDR_STATUS, '0, 1'b1);
        apb_xfer(1'b1, ADDR_REG_BASE + 12'h004, 32'hffff_ffff, 1'b1);
        apb_xfer(1'b0, 12'h008, '0, 1'b1);
        apb_xfer(1'b0, 12'h082, '0, 1'b1);
        apb_xfer(1'b0, ADDR_INST, '0, 1'b1);
        read_reg(1);

        $display("errors: %0d data, %0d response", data_errors, resp_errors);
        if (data_errors + resp_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+sim
design/mips_pkg.sv
design/apb_host_port.sv
design/inst_decode.sv
design/alu_execute.sv
design/reg_file.sv
design/mini_mips_core.sv
sim/tb_mini_mips.sv

// ==== Bender.yml ====
package:
  name: mini_mips

sources:
  - design/mips_pkg.sv
  - design/apb_host_port.sv
  - design/inst_decode.sv
  - design/alu_execute.sv
  - design/reg_file.sv
  - design/mini_mips_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mini_mips.sv
